// File: vlog.f
logic/ic_pkg.sv
logic/ic_init_sweep.sv
logic/ic_tag_way.sv
logic/ic_data_way.sv
logic/ic_nru.sv
logic/ic_way_select.sv
logic/ic_cache_array.sv
tb/ic_tb.sv

// File: tb/ic_tb.sv
`timescale 1ns/1ps

module ic_tb;

  import ic_pkg::*;

  localparam int SET_BITS = 6;
  localparam int NUM_SETS = 1 << SET_BITS;

  typedef enum {OP_IDLE, OP_READ, OP_READF, OP_FILL, OP_INV} op_t;

  typedef struct {
    op_t        op;
    line_addr_t line;
    logic [1:0] word;
    logic       hit;
    way_t       way;  // Hit way for reads, victim for fills
    logic       ev;
    line_addr_t ev_line;
    flags_t     flags;
  } entry_t;

  logic       clk = 1'b0;
  logic       rst;
  logic       rd_en;
  addr_t      rd_addr;
  logic       rd_set_flag;
  logic       rd_hit;
  way_t       rd_way;
  line_t      rd_data;
  flags_t     rd_flags;
  logic       fill_en;
  line_addr_t fill_addr;
  line_t      fill_data;
  logic       evict_valid;
  line_addr_t evict_addr;
  logic       inv;
  logic       busy;
  logic       tag_err;

  entry_t tbl [$];
  line_t  fill_vals [int];
  line_t  model [NUM_WAYS][NUM_SETS];  // Expected line per way and set
  int     errors = 0;
  int     pass_cnt = 0;
  int     fail_cnt = 0;
  int     cycles = 0;
  int     max_cycles = 1000;

  always #4 clk = ~clk;

  ic_cache_array #(.SET_BITS(SET_BITS)) uut (
    .clk(clk), .rst(rst), .rd_en(rd_en), .rd_addr(rd_addr), .rd_set_flag(rd_set_flag),
    .rd_hit(rd_hit), .rd_way(rd_way), .rd_data(rd_data), .rd_flags(rd_flags),
    .fill_en(fill_en), .fill_addr(fill_addr), .fill_data(fill_data),
    .evict_valid(evict_valid), .evict_addr(evict_addr),
    .inv(inv), .busy(busy), .tag_err(tag_err)
  );

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  function automatic line_addr_t ln(input int tag, input int set);
    return (line_addr_t'(tag) << SET_BITS) | line_addr_t'(set);
  endfunction

  function automatic int set_of(input line_addr_t l);
    return int'(l[SET_BITS-1:0]);
  endfunction

  task automatic add_entry(input op_t op, input line_addr_t line, input logic [1:0] word,
                           input logic hit, input way_t way, input logic ev,
                           input line_addr_t ev_line, input flags_t flags);
    tbl.push_back('{op, line, word, hit, way, ev, ev_line, flags});
  endtask

  task automatic check(input bit ok, input string msg);
    assert (ok) else begin
      $display("[ERROR] %0d ns: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      pass_cnt++;
      $display("ok   %s", name);
    end else begin
      fail_cnt++;
      $display("FAIL %s", name);
    end
  endtask

  // Counts falling edges while busy is high
  task automatic count_busy(output int n);
    n = 0;
    while (busy === 1'b1) begin
      n++;
      @(negedge clk);
    end
  endtask

  task automatic drive_entry(input int i);
    entry_t e;
    e = tbl[i];
    if (e.op == OP_FILL) fill_vals[i] = {$urandom(), $urandom(), $urandom(), $urandom()};
    rd_en       <= (e.op == OP_READ) || (e.op == OP_READF);
    rd_set_flag <= (e.op == OP_READF);
    rd_addr     <= {e.line, e.word, 2'b00};
    fill_en     <= (e.op == OP_FILL);
    fill_addr   <= e.line;
    fill_data   <= (e.op == OP_FILL) ? fill_vals[i] : '0;
    inv         <= (e.op == OP_INV);
  endtask

  task automatic check_entry(input int i);
    entry_t e;
    int     errs_before;
    int     n;
    e = tbl[i];
    errs_before = errors;
    case (e.op)
      OP_READ, OP_READF: begin
        check(rd_hit === e.hit, $sformatf("entry %0d rd_hit %b, expected %b", i, rd_hit, e.hit));
        check(tag_err === 1'b0, $sformatf("entry %0d tag_err set", i));
        if (e.hit) begin
          check(rd_way === e.way,
                $sformatf("entry %0d rd_way %0d, expected %0d", i, rd_way, e.way));
          check(rd_data === model[e.way][set_of(e.line)],
                $sformatf("entry %0d rd_data %h, expected %h", i, rd_data,
                          model[e.way][set_of(e.line)]));
          check(rd_flags === e.flags,
                $sformatf("entry %0d rd_flags %b, expected %b", i, rd_flags, e.flags));
        end
      end
      OP_FILL: begin
        check(evict_valid === e.ev,
              $sformatf("entry %0d evict_valid %b, expected %b", i, evict_valid, e.ev));
        if (e.ev) begin
          check(evict_addr === e.ev_line,
                $sformatf("entry %0d evict_addr %h, expected %h", i, evict_addr, e.ev_line));
        end
        model[e.way][set_of(e.line)] = fill_vals[i];
      end
      OP_INV: begin
        count_busy(n);
        check(n == NUM_SETS,
              $sformatf("entry %0d busy for %0d cycles, expected %0d", i, n, NUM_SETS));
      end
      default: ;
    endcase
    if (e.op != OP_IDLE) report_test($sformatf("entry %0d %s", i, e.op.name()), errs_before);
  endtask

  task automatic build_table();
    add_entry(OP_FILL,  ln(1, 9), 0, 0, 0, 0, 0, 4'b0000);  // Empty set fills way 0
    add_entry(OP_READ,  ln(1, 9), 0, 1, 0, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(2, 9), 0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(1, 5), 0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(2, 5), 0, 0, 1, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(3, 5), 0, 0, 2, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(1, 5), 0, 1, 0, 0, 0, 4'b0000);
    add_entry(OP_IDLE,  0,        0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(4, 5), 0, 0, 3, 0, 0, 4'b0000);  // NRU saturates to 1000
    add_entry(OP_READ,  ln(1, 5), 0, 1, 0, 0, 0, 4'b0000);  // NRU 1001
    add_entry(OP_IDLE,  0,        0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(5, 5), 0, 0, 1, 1, ln(2, 5), 4'b0000);
    add_entry(OP_READ,  ln(5, 5), 0, 1, 1, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(2, 5), 0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(3, 5), 0, 1, 2, 0, 0, 4'b0000);
    add_entry(OP_READF, ln(1, 9), 1, 1, 0, 0, 0, 4'b0010);
    add_entry(OP_READF, ln(1, 9), 3, 1, 0, 0, 0, 4'b1010);
    add_entry(OP_READ,  ln(1, 9), 0, 1, 0, 0, 0, 4'b1010);
    add_entry(OP_IDLE,  0,        0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(2, 9), 0, 0, 1, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(3, 9), 0, 0, 2, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(4, 9), 0, 0, 3, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(1, 9), 0, 0, 0, 1, ln(1, 9), 4'b0000);  // Refill of way 0
    add_entry(OP_READ,  ln(1, 9), 2, 1, 0, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(5, 5), 0, 1, 1, 0, 0, 4'b0000);  // Back-to-back reads
    add_entry(OP_READ,  ln(3, 9), 0, 1, 2, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(4, 5), 0, 1, 3, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(2, 9), 0, 1, 1, 0, 0, 4'b0000);
    add_entry(OP_INV,   0,        0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_IDLE,  0,        0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(1, 5), 0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(4, 9), 0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_FILL,  ln(6, 5), 0, 0, 0, 0, 0, 4'b0000);
    add_entry(OP_READ,  ln(6, 5), 0, 1, 0, 0, 0, 4'b0000);
    add_entry(OP_IDLE,  0,        0, 0, 0, 0, 0, 4'b0000);  // Flushes the last check
  endtask

  initial begin
    int sweep_n;
    int n;
    int errs_before;
    void'($urandom(14));
    rst         = 1'b1;
    rd_en       = 1'b0;
    rd_addr     = '0;
    rd_set_flag = 1'b0;
    fill_en     = 1'b0;
    fill_addr   = '0;
    fill_data   = '0;
    inv         = 1'b0;
    build_table();
    max_cycles = NUM_SETS + tbl.size() * 4 + 64;

    repeat (2) @(posedge clk);
    errs_before = errors;
    rst     <= 1'b0;
    rd_en   <= 1'b1;  // Read lands inside the sweep
    rd_addr <= {ln(1, 9), 4'h0};
    @(negedge clk);
    sweep_n = busy;
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);
    check(rd_hit === 1'b0, "read during the reset sweep reported a hit");
    count_busy(n);
    check(sweep_n + n == NUM_SETS,
          $sformatf("reset sweep lasted %0d cycles, expected %0d", sweep_n + n, NUM_SETS));
    report_test("reset sweep", errs_before);

    for (int i = 0; i < tbl.size(); i++) begin
      @(posedge clk);
      drive_entry(i);
      @(negedge clk);
      if (i > 0) check_entry(i - 1);
    end

    $display("Tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
    if (errors == 0 && fail_cnt == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: logic/ic_cache_array.sv
`timescale 1ns/1ps

module ic_cache_array #(
  parameter int SET_BITS = 6
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               rd_en,
  input  ic_pkg::addr_t      rd_addr,
  input  logic               rd_set_flag,
  output logic               rd_hit,
  output ic_pkg::way_t       rd_way,
  output ic_pkg::line_t      rd_data,
  output ic_pkg::flags_t     rd_flags,
  input  logic               fill_en,
  input  ic_pkg::line_addr_t fill_addr,
  input  ic_pkg::line_t      fill_data,
  output logic               evict_valid,
  output ic_pkg::line_addr_t evict_addr,
  input  logic               inv,
  output logic               busy,
  output logic               tag_err
);

  import ic_pkg::*;

  logic [SET_BITS-1:0] sweep_set;
  logic [SET_BITS-1:0] rd_set;
  logic [SET_BITS-1:0] fill_set;
  logic [SET_BITS-1:0] hit_set;
  line_addr_t          rd_line_q;
  logic [1:0]          rd_word_q;
  logic                rd_en_q;
  logic                rd_flag_q;
  logic                fill_go;
  way_vec_t            victim;
  way_vec_t            way_hit;
  way_vec_t            hit_vec;
  way_vec_t            fill_we;
  way_vec_t            flag_we;
  way_vec_t            old_valid;
  line_addr_t          old_line  [NUM_WAYS];
  line_t               way_data  [NUM_WAYS];
  flags_t              way_flags [NUM_WAYS];
  logic                victim_valid;
  line_addr_t          victim_line;

  assign rd_set   = rd_addr[SET_BITS+3:4];
  assign fill_set = fill_addr[SET_BITS-1:0];
  assign hit_set  = rd_line_q[SET_BITS-1:0];

  assign fill_go = fill_en && !busy;  // Fills dropped during sweep
  assign fill_we = victim & {NUM_WAYS{fill_go}};
  assign hit_vec = way_hit & {NUM_WAYS{rd_en_q}};
  assign flag_we = hit_vec & {NUM_WAYS{rd_flag_q}};

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_en_q     <= 1'b0;
      rd_flag_q   <= 1'b0;
      evict_valid <= 1'b0;
    end else begin
      rd_en_q     <= rd_en;
      rd_flag_q   <= rd_en && rd_set_flag;
      evict_valid <= fill_go && victim_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_line_q <= rd_addr[31:4];
      rd_word_q <= rd_addr[3:2];
    end
    if (fill_go) evict_addr <= victim_line;
  end

  // Old entry of the victim way
  always_comb begin
    victim_valid = 1'b0;
    victim_line  = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (victim[w]) begin
        victim_valid = victim_valid | old_valid[w];
        victim_line  = victim_line | old_line[w];
      end
    end
  end

  ic_init_sweep #(.SET_BITS(SET_BITS)) u_sweep (
    .clk(clk), .rst(rst), .inv(inv), .busy(busy), .sweep_set(sweep_set)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    ic_tag_way #(.SET_BITS(SET_BITS)) u_tag (
      .clk(clk), .rst(rst), .busy(busy), .sweep_set(sweep_set),
      .rd_en(rd_en), .rd_set(rd_set), .rd_line(rd_line_q),
      .fill_we(fill_we[w]), .fill_set(fill_set), .fill_line(fill_addr),
      .hit(way_hit[w]), .old_valid(old_valid[w]), .old_line(old_line[w])
    );

    ic_data_way #(.SET_BITS(SET_BITS)) u_data (
      .clk(clk), .rd_en(rd_en), .rd_set(rd_set),
      .rd_data(way_data[w]), .rd_flags(way_flags[w]),
      .fill_we(fill_we[w]), .fill_set(fill_set), .fill_data(fill_data),
      .flag_we(flag_we[w]), .flag_word(rd_word_q),
      .busy(busy), .sweep_set(sweep_set)
    );
  end

  ic_nru #(.SET_BITS(SET_BITS)) u_nru (
    .clk(clk), .rst(rst), .busy(busy), .sweep_set(sweep_set),
    .fill_en(fill_go), .fill_set(fill_set), .victim(victim),
    .hit_vec(hit_vec), .hit_set(hit_set)
  );

  ic_way_select u_select (
    .clk(clk), .rst(rst), .hit_vec(hit_vec),
    .way_data(way_data), .way_flags(way_flags),
    .rd_hit(rd_hit), .rd_way(rd_way), .rd_data(rd_data),
    .rd_flags(rd_flags), .tag_err(tag_err)
  );

endmodule

// File: logic/ic_way_select.sv
`timescale 1ns/1ps

module ic_way_select (
  input  logic             clk,
  input  logic             rst,
  input  ic_pkg::way_vec_t hit_vec,
  input  ic_pkg::line_t    way_data  [ic_pkg::NUM_WAYS],
  input  ic_pkg::flags_t   way_flags [ic_pkg::NUM_WAYS],
  output logic             rd_hit,
  output ic_pkg::way_t     rd_way,
  output ic_pkg::line_t    rd_data,
  output ic_pkg::flags_t   rd_flags,
  output logic             tag_err
);

  import ic_pkg::*;

  // AND-OR over the one-hot hits
  always_comb begin
    rd_data  = '0;
    rd_flags = '0;
    rd_way   = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_vec[w]) begin
        rd_data  = rd_data | way_data[w];
        rd_flags = rd_flags | way_flags[w];
        rd_way   = rd_way | way_t'(w);  // Encoder
      end
    end
  end

  assign rd_hit = |hit_vec;

  // More than one bit set
  assign tag_err = (hit_vec & (hit_vec - 1'b1)) != '0;

  a_hit_onehot0: assert property (@(posedge clk) disable iff (rst)
    $onehot0(hit_vec))
    else $error("multiple ways hit");

endmodule

// File: logic/ic_nru.sv
`timescale 1ns/1ps

module ic_nru #(
  parameter int SET_BITS = 6
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                busy,
  input  logic [SET_BITS-1:0] sweep_set,
  input  logic                fill_en,
  input  logic [SET_BITS-1:0] fill_set,
  output ic_pkg::way_vec_t    victim,
  input  ic_pkg::way_vec_t    hit_vec,
  input  logic [SET_BITS-1:0] hit_set
);

  import ic_pkg::*;

  localparam int NUM_SETS = 1 << SET_BITS;

  way_vec_t nru_mem [NUM_SETS];
  way_vec_t fill_cur;
  logic     hit_any;
  logic     same_set;

  // Mark the used ways and keep only those once every way is marked
  function automatic way_vec_t nru_next(way_vec_t cur, way_vec_t mark);
    way_vec_t merged;
    merged = cur | mark;
    return (&merged) ? mark : merged;
  endfunction

  assign fill_cur = nru_mem[fill_set];
  assign hit_any  = |hit_vec;
  assign same_set = hit_any && fill_en && (hit_set == fill_set);

  // Lowest way not recently used
  assign victim = ~fill_cur & (fill_cur + 1'b1);

  always_ff @(posedge clk) begin
    if (rst || busy) begin
      nru_mem[sweep_set] <= '0;
    end else if (same_set) begin
      nru_mem[fill_set] <= nru_next(fill_cur, hit_vec | victim);  // Merged update
    end else begin
      if (hit_any) nru_mem[hit_set] <= nru_next(nru_mem[hit_set], hit_vec);
      if (fill_en) nru_mem[fill_set] <= nru_next(fill_cur, victim);
    end
  end

  a_victim_onehot: assert property (@(posedge clk) disable iff (rst || busy)
    fill_en |-> $onehot(victim))
    else $error("victim not one-hot on fill");

endmodule

// File: logic/ic_data_way.sv
`timescale 1ns/1ps

module ic_data_way #(
  parameter int SET_BITS = 6
) (
  input  logic                clk,
  input  logic                rd_en,
  input  logic [SET_BITS-1:0] rd_set,
  output ic_pkg::line_t       rd_data,
  output ic_pkg::flags_t      rd_flags,
  input  logic                fill_we,
  input  logic [SET_BITS-1:0] fill_set,
  input  ic_pkg::line_t       fill_data,
  input  logic                flag_we,
  input  logic [1:0]          flag_word,
  input  logic                busy,
  input  logic [SET_BITS-1:0] sweep_set
);

  import ic_pkg::*;

  localparam int NUM_SETS = 1 << SET_BITS;

  line_t               line_mem [NUM_SETS];
  flags_t              flag_mem [NUM_SETS];
  logic [SET_BITS-1:0] rd_idx;
  flags_t              flag_bit;

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_idx <= rd_set;
    end
  end

  assign rd_data = line_mem[rd_idx];

  assign flag_bit = flags_t'(1'b1) << flag_word;

  // Word bit shows up in the same cycle it is marked
  assign rd_flags = flag_mem[rd_idx] | (flag_bit & {$bits(flags_t){flag_we}});

  always_ff @(posedge clk) begin
    if (fill_we) begin
      line_mem[fill_set] <= fill_data;
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      flag_mem[sweep_set] <= '0;
    end else begin
      if (flag_we) begin
        flag_mem[rd_idx] <= rd_flags;  // Read-modify-write
      end
      // Refill of the same entry wins over the flag update
      if (fill_we) begin
        flag_mem[fill_set] <= '0;
      end
    end
  end

endmodule

// File: logic/ic_tag_way.sv
`timescale 1ns/1ps

module ic_tag_way #(
  parameter int SET_BITS = 6
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                busy,
  input  logic [SET_BITS-1:0] sweep_set,
  input  logic                rd_en,
  input  logic [SET_BITS-1:0] rd_set,
  input  ic_pkg::line_addr_t  rd_line,
  input  logic                fill_we,
  input  logic [SET_BITS-1:0] fill_set,
  input  ic_pkg::line_addr_t  fill_line,
  output logic                hit,
  output logic                old_valid,
  output ic_pkg::line_addr_t  old_line
);

  import ic_pkg::*;

  localparam int NUM_SETS = 1 << SET_BITS;

  line_addr_t          tag_mem [NUM_SETS];
  logic [NUM_SETS-1:0] valid;
  logic [SET_BITS-1:0] rd_idx;

  // Read index, held until the next read
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_idx <= '0;
    end else if (rd_en) begin
      rd_idx <= rd_set;
    end
  end

  always_ff @(posedge clk) begin
    if (busy) begin
      valid[sweep_set] <= 1'b0;
    end else if (fill_we) begin
      tag_mem[fill_set] <= fill_line;
      valid[fill_set]   <= 1'b1;
    end
  end

  // rd_line arrives already delayed to line up with rd_idx
  assign hit = !busy && valid[rd_idx] && (tag_mem[rd_idx] == rd_line);

  // Entry about to be replaced
  assign old_valid = valid[fill_set];
  assign old_line  = tag_mem[fill_set];

  // Top must hold fills off for the whole sweep
  a_no_fill_in_sweep: assert property (@(posedge clk) disable iff (rst)
    busy |-> !fill_we)
    else $error("fill write during sweep");

endmodule

// File: logic/ic_init_sweep.sv
`timescale 1ns/1ps

module ic_init_sweep #(
  parameter int SET_BITS = 6
) (
  input  logic                clk,
  input  logic                rst,
  input  logic                inv,
  output logic                busy,
  output logic [SET_BITS-1:0] sweep_set
);

  typedef enum logic {
    IDLE,
    SWEEP
  } state_t;

  localparam logic [SET_BITS-1:0] LAST_SET = {SET_BITS{1'b1}};

  state_t state;

  always_ff @(posedge clk) begin
    if (rst || inv) begin
      state     <= SWEEP;  // Restart from set 0
      sweep_set <= '0;
    end else if (state == SWEEP) begin
      sweep_set <= sweep_set + 1'b1;  // Wraps back to 0 at the end
      if (sweep_set == LAST_SET) begin
        state <= IDLE;
      end
    end
  end

  assign busy = (state == SWEEP);

  // Index parks at 0 between sweeps
  a_sweep_parked: assert property (@(posedge clk) disable iff (rst)
    !busy |=> $stable(sweep_set))
    else $error("sweep_set moved while idle");

endmodule

// File: logic/ic_pkg.sv
package ic_pkg;

  // Fixed associativity, sizes the NRU vectors and the way select
  localparam int NUM_WAYS = 4;

  // Fetch byte address
  typedef logic [31:0] addr_t;

  // Byte address without the 4 offset bits, stored whole as the tag
  typedef logic [27:0] line_addr_t;

  typedef logic [127:0] line_t;  // One 16-byte line

  typedef logic [3:0] flags_t;  // One bit per 32-bit word

  typedef logic [1:0] way_t;

  // Hits, NRU bits and victim one-hot
  typedef logic [NUM_WAYS-1:0] way_vec_t;

endpackage
